/* Bender.yml */
package:
  name: tetris_playfield

sources:
  - include_dirs:
      - logic
    files:
      - logic/tetris_board_pkg.sv
      - logic/tetris_cmd_pkg.sv
      - logic/playfield_ram.sv
      - logic/cmd_fifo.sv
      - logic/tetris_apb_regs.sv
      - logic/piece_engine.sv
      - logic/tetris_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tetris_checker.sv
      - verification/tetris_tb.sv

/* logic/cmd_fifo.sv */
`include "tetris_defines.svh"

module cmd_fifo
	import tetris_cmd_pkg::*;
#(
	parameter int DEPTH = `CMD_DEPTH
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      push_i,
	input  cmd_word_u wdata_i,
	input  logic      pop_i,
	output cmd_word_u head_o,
	output logic      full_o,
	output logic      empty_o
);

	localparam int AW = $clog2(DEPTH);

	cmd_word_u     mem [DEPTH];
	logic [AW-1:0] rptr;
	logic [AW-1:0] wptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign full_o  = (count == DEPTH[AW:0]);
	assign empty_o = (count == '0);
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;
	assign head_o  = mem[rptr]; // show-ahead

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wptr] <= wdata_i;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rptr  <= '0;
			wptr  <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wptr <= wptr + 1'b1; // wraps at DEPTH
			if (do_pop)
				rptr <= rptr + 1'b1;
			count <= count + do_push - do_pop;
		end
	end

endmodule : cmd_fifo

/* logic/piece_engine.sv */
`include "tetris_defines.svh"

module piece_engine
	import tetris_board_pkg::*;
	import tetris_cmd_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      empty_i,
	input  cmd_word_u head_i,
	output logic      pop_o,
	output status_t   status_o
);

	localparam logic [2:0] S_CLEAR  = 3'd0;
	localparam logic [2:0] S_IDLE   = 3'd1;
	localparam logic [2:0] S_CHECK  = 3'd2;
	localparam logic [2:0] S_COMMIT = 3'd3;
	localparam logic [2:0] S_LOCK   = 3'd4;

	localparam logic [1:0] K_SPAWN = 2'd0;
	localparam logic [1:0] K_DOWN  = 2'd1;
	localparam logic [1:0] K_SIDE  = 2'd2;

	localparam cell_idx_t LAST_CELL = cell_idx_t'(`BOARD_W * `BOARD_H - 1);

	logic [2:0] state;
	cell_idx_t  clr_idx;  // clear sweep address
	logic [1:0] sq;       // square count
	logic       phase;    // 0 read issue, 1 read data
	logic       blocked;
	logic       sq_oob;
	logic [1:0] kind;
	coord_x_t   tgt_x;
	coord_y_t   tgt_y;
	shape_t     tgt_shape;
	coord_x_t   anchor_x;
	coord_y_t   anchor_y;
	shape_t     shape;
	logic       active;
	logic       game_over;
	logic [7:0] locked_cnt;

	coord_x_t   base_x;
	coord_y_t   base_y;
	shape_t     base_shape;
	logic [3:0] ofs;
	logic [5:0] cx;
	logic [5:0] cy;
	logic       inb;
	cell_idx_t  idx;
	cell_idx_t  raddr;
	color_t     rdata;
	logic       we;
	cell_idx_t  waddr;
	color_t     wdata;
	logic       hit;

	// lock walks the resting piece, check walks the target
	always_comb
	begin
		base_x     = (state == S_LOCK) ? anchor_x : tgt_x;
		base_y     = (state == S_LOCK) ? anchor_y : tgt_y;
		base_shape = (state == S_LOCK) ? shape : tgt_shape;
		ofs        = shape_offset(base_shape, sq);
		cx         = {1'b0, base_x} + {4'b0, ofs[3:2]};
		cy         = base_y + {4'b0, ofs[1:0]};
		inb        = (cx < `BOARD_W) && (cy < `BOARD_H);
		idx        = cell_idx_t'(cy * `BOARD_W + cx);
	end

	assign raddr = inb ? idx : '0; // keep reads inside the array
	assign hit   = sq_oob | (rdata != `COLOR_EMPTY);
	assign we    = (state == S_CLEAR) | (state == S_LOCK);
	assign waddr = (state == S_CLEAR) ? clr_idx : idx;
	assign wdata = (state == S_CLEAR) ? `COLOR_EMPTY : color_t'(shape);
	assign pop_o = (state == S_IDLE) & ~empty_i;

	always_comb
	begin
		status_o.game_over = game_over;
		status_o.active    = active;
		status_o.busy      = (state != S_IDLE);
		status_o.locked    = locked_cnt;
		status_o.shape     = shape;
		status_o.row       = anchor_y;
		status_o.col       = anchor_x;
	end

	playfield_ram u_board (
		.clk     (clk),
		.raddr_i (raddr),
		.we_i    (we),
		.waddr_i (waddr),
		.wdata_i (wdata),
		.rdata_o (rdata)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= S_CLEAR;
			clr_idx    <= '0;
			sq         <= '0;
			phase      <= 1'b0;
			kind       <= K_SPAWN;
			anchor_x   <= '0;
			anchor_y   <= '0;
			shape      <= '0;
			active     <= 1'b0;
			game_over  <= 1'b0;
			locked_cnt <= '0;
		end
		else
		begin
			case (state)
				S_CLEAR:
				begin
					clr_idx <= clr_idx + 1'b1;
					if (clr_idx == LAST_CELL)
						state <= S_IDLE;
				end
				S_IDLE:
				begin
					sq      <= '0;
					phase   <= 1'b0;
					blocked <= 1'b0;
					if (pop_o && !game_over)
					begin
						if (head_i.spawn.op)
						begin
							if (!active) // no spawn over a live piece
							begin
								tgt_x     <= head_i.spawn.col;
								tgt_y     <= '0;
								tgt_shape <= head_i.spawn.shape;
								kind      <= K_SPAWN;
								state     <= S_CHECK;
							end
						end
						else if (active)
						begin
							tgt_x     <= anchor_x;
							tgt_y     <= anchor_y;
							tgt_shape <= shape;
							case (head_i.key.keycode)
								`KEY_DOWN:
								begin
									tgt_y <= anchor_y + 1'b1;
									kind  <= K_DOWN;
									state <= S_CHECK;
								end
								`KEY_LEFT:
								begin
									tgt_x <= anchor_x - 1'b1; // column 0 wraps out of bounds
									kind  <= K_SIDE;
									state <= S_CHECK;
								end
								`KEY_RIGHT:
								begin
									tgt_x <= anchor_x + 1'b1;
									kind  <= K_SIDE;
									state <= S_CHECK;
								end
								default: ; // unknown key dropped
							endcase
						end
					end
				end
				S_CHECK:
				begin
					if (!phase)
					begin
						sq_oob <= ~inb;
						phase  <= 1'b1;
					end
					else
					begin
						phase   <= 1'b0;
						blocked <= blocked | hit;
						sq      <= sq + 1'b1; // back to 0 for lock
						if (sq == 2'd3)
							state <= S_COMMIT;
					end
				end
				S_COMMIT:
				begin
					state <= S_IDLE;
					if (!blocked)
					begin
						anchor_x <= tgt_x;
						anchor_y <= tgt_y;
						shape    <= tgt_shape;
						active   <= 1'b1;
					end
					else if (kind == K_SPAWN)
						game_over <= 1'b1;
					else if (kind == K_DOWN)
						state <= S_LOCK;
				end
				S_LOCK:
				begin
					sq <= sq + 1'b1;
					if (sq == 2'd3)
					begin
						locked_cnt <= locked_cnt + 1'b1;
						active     <= 1'b0;
						state      <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule : piece_engine

/* logic/playfield_ram.sv */
`include "tetris_defines.svh"

module playfield_ram
	import tetris_board_pkg::*;
(
	input  logic      clk,
	input  cell_idx_t raddr_i,
	input  logic      we_i,
	input  cell_idx_t waddr_i,
	input  color_t    wdata_i,
	output color_t    rdata_o
);

	localparam int CELLS = `BOARD_W * `BOARD_H;

	color_t mem [CELLS];

	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
		rdata_o <= mem[raddr_i]; // one cycle read latency
	end

endmodule : playfield_ram

/* logic/tetris_apb_regs.sv */
`include "tetris_defines.svh"

module tetris_apb_regs
	import tetris_cmd_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [3:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	input  logic        full_i,
	input  status_t     status_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        push_o,
	output cmd_word_u   cmd_o
);

	logic pending; // setup or waiting access cycle
	logic cmd_wr;
	logic pready_d;
	logic rd_status;

	always_comb
	begin
		pending   = psel_i & (~penable_i | ~pready_o);
		cmd_wr    = pwrite_i & (paddr_i == `ADDR_CMD);
		pready_d  = pending & ~(cmd_wr & full_i); // hold off while FIFO full
		rd_status = pready_d & ~pwrite_i & (paddr_i == `ADDR_STATUS);
	end

	// one push, in the completing access cycle
	assign push_o = psel_i & penable_i & pready_o & cmd_wr;
	assign cmd_o  = cmd_word_u'(pwdata_i[15:0]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pready_o <= 1'b0;
		end
		else
		begin
			pready_o <= pready_d;
		end
	end

	always_ff @(posedge clk)
	begin
		prdata_o <= rd_status ? {8'h00, status_i} : 32'h0; // unmapped reads give 0
	end

endmodule : tetris_apb_regs

/* logic/tetris_board_pkg.sv */
package tetris_board_pkg;

	// column, 0 is the left edge
	typedef logic [4:0] coord_x_t;

	// row, 0 is the top where pieces spawn
	typedef logic [5:0] coord_y_t;

	// square colour, shape index for locked squares, 7 is empty
	typedef logic [2:0] color_t;

	// flat board address, row * BOARD_W + column
	typedef logic [9:0] cell_idx_t;

endpackage : tetris_board_pkg

/* logic/tetris_cmd_pkg.sv */
package tetris_cmd_pkg;
	import tetris_board_pkg::*;

	typedef logic [1:0] shape_t; // also the locked colour

	typedef struct packed {
		logic       op;      // 0 for a key
		logic [6:0] unused;
		logic [7:0] keycode;
	} cmd_key_t;

	typedef struct packed {
		logic       op;      // 1 for a spawn
		logic [7:0] unused;
		shape_t     shape;
		coord_x_t   col;
	} cmd_spawn_t;

	typedef union packed {
		cmd_key_t   key;
		cmd_spawn_t spawn;
	} cmd_word_u;

	typedef struct packed {
		logic       game_over;
		logic       active;
		logic       busy;
		logic [7:0] locked;
		shape_t     shape;
		coord_y_t   row;
		coord_x_t   col;
	} status_t;

	// square offset from the anchor, returned as {dx, dy}
	function automatic logic [3:0] shape_offset(input shape_t shape, input logic [1:0] sq);
		logic [3:0] ofs;
		case (shape)
			2'd0: ofs = sq[1] ? {1'b0, sq[0], 2'd1} : {1'b0, sq[0], 2'd0}; // O
			2'd1: ofs = {2'd0, sq}; // I
			2'd2: ofs = (sq == 2'd3) ? {2'd1, 2'd2} : {2'd0, sq}; // L
			default: ofs = (sq == 2'd3) ? {2'd1, 2'd1} : {sq, 2'd0}; // T
		endcase
		return ofs;
	endfunction

endpackage : tetris_cmd_pkg

/* logic/tetris_defines.svh */
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// playfield size in squares
`define BOARD_W 21
`define BOARD_H 41

`define COLOR_EMPTY 3'd7 // white

`define CMD_DEPTH 4 // command FIFO entries, power of two

// APB register map
`define ADDR_CMD    4'h0
`define ADDR_STATUS 4'h4

// keyboard scan codes
`define KEY_DOWN  8'h51
`define KEY_LEFT  8'h50
`define KEY_RIGHT 8'h4F

`endif

/* logic/tetris_top.sv */
module tetris_top
	import tetris_cmd_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [3:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o
);

	logic      push;
	cmd_word_u cmd;
	logic      full;
	logic      empty;
	cmd_word_u head;
	logic      pop;
	status_t   status;

	tetris_apb_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.full_i    (full),
		.status_i  (status),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.push_o    (push),
		.cmd_o     (cmd)
	);

	cmd_fifo u_fifo (
		.clk     (clk),
		.reset   (reset),
		.push_i  (push),
		.wdata_i (cmd),
		.pop_i   (pop),
		.head_o  (head),
		.full_o  (full),
		.empty_o (empty)
	);

	piece_engine u_engine (
		.clk      (clk),
		.reset    (reset),
		.empty_i  (empty),
		.head_i   (head),
		.pop_o    (pop),
		.status_o (status)
	);

endmodule : tetris_top

/* tb.f */
+incdir+logic
logic/tetris_board_pkg.sv
logic/tetris_cmd_pkg.sv
logic/playfield_ram.sv
logic/cmd_fifo.sv
logic/tetris_apb_regs.sv
logic/piece_engine.sv
logic/tetris_top.sv
verification/tetris_checker.sv
verification/tetris_tb.sv

/* verification/tetris_checker.sv */
`include "tetris_defines.svh"

module tetris_checker
#(
	parameter int DEPTH = `CMD_DEPTH
)
(
	input logic                   clk,
	input logic                   reset,
	input logic                   push_i,
	input logic                   pop_i,
	input logic                   full_i,
	input logic                   empty_i,
	input logic [$clog2(DEPTH):0] count_i
);

	int fail_count = 0;

	// the APB side holds pready low while the FIFO is full
	no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push_i && full_i))
		else
		begin
			fail_count++;
			$error("push offered while the command FIFO is full");
		end

	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(pop_i && empty_i))
		else
		begin
			fail_count++;
			$error("pop issued while the command FIFO is empty");
		end

	count_in_range: assert property (@(posedge clk) disable iff (reset) count_i <= DEPTH)
		else
		begin
			fail_count++;
			$error("command FIFO count above its depth");
		end

endmodule : tetris_checker

bind cmd_fifo tetris_checker #(.DEPTH(DEPTH)) fifo_chk (
	.clk     (clk),
	.reset   (reset),
	.push_i  (push_i),
	.pop_i   (pop_i),
	.full_i  (full_o),
	.empty_i (empty_o),
	.count_i (count)
);

/* verification/tetris_tb.sv */
`include "tetris_defines.svh"

module tetris_tb
	import tetris_cmd_pkg::*;
();

	localparam int CELLS    = `BOARD_W * `BOARD_H;
	localparam int N_SIDE   = 20; // random side keys on the first piece
	localparam int N_PIECES = 6;
	localparam int N_MOVES  = 4;  // side keys per later piece
	localparam int N_BURST  = 12;
	localparam int N_AFTER  = 8;  // commands sent after game over
	localparam int MAX_DROP = `BOARD_H + 1;
	localparam int MAX_CMDS = 2 + N_SIDE + MAX_DROP + N_PIECES * (1 + N_MOVES + MAX_DROP)
		+ N_BURST + MAX_DROP + 1 + N_AFTER;
	localparam int TIMEOUT  = (CELLS + 20 + MAX_CMDS * 40) * 20;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;

	// reference model state
	logic [2:0]  board_m [CELLS];
	int          ax;
	int          ay;
	int          mshape;
	bit          mactive;
	bit          mgo;
	logic [7:0]  mlocked;

	tetris_top dut (
		.clk       (clk),
		.reset     (reset),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT);
		$display("Timeout: the command sequence did not finish in %0d time units", TIMEOUT);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "check %s failed", name);
		end
	endtask

	// shape table with the I vertical, the L foot on the right and the T pointing down
	function automatic int sq_dx(input int shp, input int s);
		case (shp)
			0: return s % 2;
			1: return 0;
			2: return (s == 3) ? 1 : 0;
			default: return (s == 3) ? 1 : s;
		endcase
	endfunction

	function automatic int sq_dy(input int shp, input int s);
		case (shp)
			0: return s / 2;
			1: return s;
			2: return (s == 3) ? 2 : s;
			default: return (s == 3) ? 1 : 0;
		endcase
	endfunction

	function automatic bit cell_free(input int x, input int y);
		if (x >= `BOARD_W || y >= `BOARD_H)
			return 1'b0;
		return board_m[y * `BOARD_W + x] == `COLOR_EMPTY;
	endfunction

	function automatic bit piece_fits(input int x, input int y, input int shp);
		for (int s = 0; s < 4; s++)
		begin
			if (!cell_free(x + sq_dx(shp, s), y + sq_dy(shp, s)))
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic lock_piece();
		for (int s = 0; s < 4; s++)
			board_m[(ay + sq_dy(mshape, s)) * `BOARD_W + ax + sq_dx(mshape, s)] = 3'(mshape);
		mlocked = mlocked + 1'b1;
		mactive = 1'b0;
	endtask

	task automatic model_apply(input logic [15:0] w);
		int tx;
		int ty;
		if (mgo)
			return; // everything ignored until reset
		if (w[15])
		begin
			if (mactive)
				return;
			if (piece_fits(w[4:0], 0, w[6:5]))
			begin
				ax      = w[4:0];
				ay      = 0;
				mshape  = w[6:5];
				mactive = 1'b1;
			end
			else
				mgo = 1'b1;
			return;
		end
		if (!mactive)
			return;
		tx = ax;
		ty = ay;
		case (w[7:0])
			`KEY_DOWN:  ty = ay + 1;
			`KEY_LEFT:  tx = (ax - 1) & 31; // 5-bit column so 0 wraps off the board
			`KEY_RIGHT: tx = ax + 1;
			default:    return;
		endcase
		if (piece_fits(tx, ty, mshape))
		begin
			ax = tx;
			ay = ty;
		end
		else if (w[7:0] == `KEY_DOWN)
			lock_piece();
	endtask

	function automatic status_t expected_status();
		status_t st;
		st.game_over = mgo;
		st.active    = mactive;
		st.busy      = 1'b0;
		st.locked    = mlocked;
		st.shape     = shape_t'(mshape);
		st.row       = 6'(ay);
		st.col       = 5'(ax);
		return st;
	endfunction

	// starts and returns 2 units after a rising edge
	task automatic apb_transfer(input bit wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		while (!pready) // FIFO full back-pressure
		begin
			@(posedge clk);
			#2;
		end
		rdata = prdata;
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic [15:0] key_word(input logic [7:0] key);
		return {1'b0, 7'($urandom), key};
	endfunction

	function automatic logic [15:0] spawn_word(input logic [1:0] shp, input logic [4:0] col);
		return {1'b1, 8'($urandom), shp, col};
	endfunction

	function automatic logic [15:0] random_key(input bit allow_down);
		logic [7:0] k;
		case ($urandom % 4)
			0: k = `KEY_LEFT;
			1: k = `KEY_RIGHT;
			2: k = allow_down ? `KEY_DOWN : `KEY_LEFT;
			default:
			begin
				k = 8'($urandom);
				if (k == `KEY_DOWN || k == `KEY_LEFT || k == `KEY_RIGHT)
					k = 8'h00; // keep it unknown
			end
		endcase
		return key_word(k);
	endfunction

	function automatic logic [15:0] legal_spawn();
		return spawn_word(2'($urandom), 5'($urandom % (`BOARD_W - 2)));
	endfunction

	task automatic send_cmd(input logic [15:0] w);
		logic [31:0] unused_rd;
		model_apply(w);
		apb_transfer(1'b1, `ADDR_CMD, {16'($urandom), w}, unused_rd);
	endtask

	// idle must outlast a FIFO drain of ignored commands at one per cycle
	task automatic wait_idle(output logic [31:0] rd);
		int idle_reads;
		status_t st;
		idle_reads = 0;
		while (idle_reads < 4)
		begin
			apb_transfer(1'b0, `ADDR_STATUS, 32'h0, rd);
			st = rd[23:0];
			if (st.busy)
				idle_reads = 0;
			else
				idle_reads++;
		end
	endtask

	task automatic check_status(input string name, output logic [31:0] rd);
		wait_idle(rd);
		check_value(name, {8'h00, expected_status()}, rd);
	endtask

	task automatic drop_piece(input string name);
		int n;
		logic [31:0] rd;
		n = 0;
		while (mactive && n < MAX_DROP)
		begin
			send_cmd(key_word(`KEY_DOWN));
			check_status(name, rd);
			n++;
		end
	endtask

	initial
	begin
		logic [31:0] rd;
		void'($urandom(23036));
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 4'h0;
		pwdata  = 32'h0;
		for (int c = 0; c < CELLS; c++)
			board_m[c] = `COLOR_EMPTY;
		ax      = 0;
		ay      = 0;
		mshape  = 0;
		mactive = 1'b0;
		mgo     = 1'b0;
		mlocked = 8'h00;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		check_status("after_clear", rd);
		apb_transfer(1'b0, 4'h8, 32'h0, rd);
		check_value("unmapped_read", 32'h0, rd);

		send_cmd(legal_spawn());
		check_status("spawn", rd);
		send_cmd(legal_spawn());
		check_status("spawn_while_active", rd);

		for (int i = 0; i < N_SIDE; i++)
		begin
			send_cmd(random_key(1'b0));
			check_status("side_move", rd);
		end
		drop_piece("first_drop");

		// later pieces land on the stack
		for (int p = 0; p < N_PIECES; p++)
		begin
			send_cmd(legal_spawn());
			check_status("stack_spawn", rd);
			for (int i = 0; i < N_MOVES; i++)
			begin
				send_cmd(random_key(1'b0));
				check_status("stack_side", rd);
			end
			drop_piece("stack_drop");
		end

		send_cmd(legal_spawn());
		for (int i = 1; i < N_BURST; i++)
			send_cmd(random_key(1'b1)); // back to back so the FIFO fills
		check_status("burst", rd);

		drop_piece("pre_game_over_drop");
		send_cmd(spawn_word(2'($urandom), 5'(`BOARD_W + $urandom % 11)));
		check_status("spawn_off_edge", rd);
		check_value("game_over_set", 32'd1, {31'd0, rd[23]});
		for (int i = 0; i < N_AFTER; i++)
		begin
			if ($urandom % 2)
				send_cmd(legal_spawn());
			else
				send_cmd(random_key(1'b1));
			check_status("after_game_over", rd);
		end

		if (dut.u_fifo.fifo_chk.fail_count != 0)
		begin
			$display("FIFO assertions failed %0d times", dut.u_fifo.fifo_chk.fail_count);
			$display("*** FAILED ***");
			$fatal(1, "FIFO assertion failures");
		end
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule : tetris_tb
